/* tb.f */
lsu_pkg.sv
lsu_config_regs.sv
lsu_access_decoder.sv
data_memory.sv
load_aligner.sv
load_store_unit.sv
tb_load_store_unit.sv

/* tb_load_store_unit.sv */
// Self-checking testbench for load_store_unit
// LFSR stimulus against a byte shadow memory and concurrent assertions that check the results
module tb_load_store_unit;

    logic                               memory_done;
    logic                               rst_n;
    logic [6:0]                         opcode;
    logic [2:0]                         funct3;
    logic [lsu_pkg::xlen-1:0]           address;
    logic [lsu_pkg::xlen-1:0]           store_data;
    logic [lsu_pkg::xlen-1:0]           load_data;
    logic                               load_valid;
    logic                               fault;
    logic                               cfg_we;
    logic [lsu_pkg::cfg_addr_width-1:0] cfg_addr;
    logic [lsu_pkg::xlen-1:0]           cfg_wdata;
    logic [lsu_pkg::xlen-1:0]           cfg_rdata;

    logic [7:0]                      shadow [4*lsu_pkg::mem_depth]; // Byte image of memory
    logic [lsu_pkg::xlen+1:0]        exp_q [$];  // One {valid, fault, data} entry per cycle
    logic                            exp_valid;
    logic                            exp_fault;
    logic [lsu_pkg::xlen-1:0]        exp_data;
    logic [lsu_pkg::xlen-1:0]        cfg_exp;
    logic                            cfg_check;
    logic                            reset_check;
    logic [lsu_pkg::window_bits-1:0] window_model;
    int                              fault_total;
    int                              failures;
    logic [31:0]                     lfsr_state;

    load_store_unit DUT (.*);

    initial
    begin
        memory_done = 1'b0;
        forever #4 memory_done = ~memory_done;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // Taps 32, 22, 2, 1
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    task automatic abort_run(input string what);
        failures++;
        $display("%s", what);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] want);
        abort_run($sformatf("[FAIL] %s got 0x%h expected 0x%h", name, got, want));
    endtask

    // Load result built from the shadow bytes by access size
    function automatic logic [31:0] expected_load(input logic [2:0] f3, input logic [9:0] a);
        logic [9:0] w;
        w = {a[9:2], 2'b00};
        case (f3)
            lsu_pkg::f3_b:  return {{24{shadow[a][7]}}, shadow[a]};
            lsu_pkg::f3_h:  return {{16{shadow[a+1][7]}}, shadow[a+1], shadow[a]};
            lsu_pkg::f3_bu: return {24'd0, shadow[a]};
            lsu_pkg::f3_hu: return {16'd0, shadow[a+1], shadow[a]};
            default:        return {shadow[w+3], shadow[w+2], shadow[w+1], shadow[w]};
        endcase
    endfunction

    task automatic begin_cycle;
        @(posedge memory_done);
        #1;
        opcode      = 7'd0; // Idle unless the caller overrides
        funct3      = 3'd0;
        address     = '0;
        store_data  = '0;
        cfg_we      = 1'b0;
        cfg_check   = 1'b0;
        reset_check = 1'b0;
    endtask

    // Expectation of the cycle just driven and of the one due two edges later
    task automatic finish_cycle;
        logic        is_ld;
        logic        is_st;
        logic        bad_align;
        logic        flt;
        logic [31:0] ld_val;
        logic [9:0]  a;
        is_ld     = (opcode == lsu_pkg::opcode_load);
        is_st     = (opcode == lsu_pkg::opcode_store);
        a         = address[9:0];
        bad_align = ((funct3 == lsu_pkg::f3_h || funct3 == lsu_pkg::f3_hu) && address[0]) ||
                    (funct3 == lsu_pkg::f3_w && address[1:0] != 2'b00);
        flt = (is_ld || is_st) &&
              (bad_align || address[31 -: lsu_pkg::window_bits] != window_model);
        ld_val = '0;
        if (is_ld && !flt)
            ld_val = expected_load(funct3, a);
        if (is_st && !flt)
        begin
            shadow[a] = store_data[7:0];
            if (funct3 != lsu_pkg::f3_b)
                shadow[a+1] = store_data[15:8];
            if (funct3 == lsu_pkg::f3_w)
            begin
                shadow[a+2] = store_data[23:16];
                shadow[a+3] = store_data[31:24];
            end
        end
        if (flt)
            fault_total++;
        exp_q.push_back({is_ld && !flt, flt, ld_val});
        if (exp_q.size() == 3)
            {exp_valid, exp_fault, exp_data} = exp_q.pop_front();
    endtask

    task automatic issue(input logic [6:0] op, input logic [2:0] f3,
                         input logic [31:0] addr, input logic [31:0] data);
        begin_cycle();
        opcode     = op;
        funct3     = f3;
        address    = addr;
        store_data = data;
        finish_cycle();
    endtask

    task automatic write_cfg(input logic [1:0] a, input logic [31:0] d);
        begin_cycle();
        cfg_we    = 1'b1;
        cfg_addr  = a;
        cfg_wdata = d;
        if (a == lsu_pkg::cfg_window_base)
            window_model = d[lsu_pkg::window_bits-1:0];
        else if (a == lsu_pkg::cfg_fault_count)
            fault_total = 0;
        finish_cycle();
    endtask

    task automatic read_cfg(input logic [1:0] a, input logic [31:0] want);
        begin_cycle();
        cfg_addr  = a;
        cfg_exp   = want;
        cfg_check = 1'b1;
        finish_cycle();
    endtask

    task automatic flush(input int max_cycles);
        int n;
        int pending;
        n = 0;
        pending = 1;
        while (pending != 0 && n < max_cycles)
        begin
            issue(7'd0, 3'd0, 0, 0);
            pending = exp_valid || exp_fault;
            foreach (exp_q[k])
                pending += exp_q[k][33] | exp_q[k][32];
            n++;
        end
        if (pending != 0)
            abort_run("Timed out draining the load pipeline");
    endtask

    check_valid: assert property (@(posedge memory_done) disable iff (!rst_n)
        load_valid === exp_valid)
        else report_mismatch("load_valid", $sampled(load_valid), $sampled(exp_valid));
    check_fault: assert property (@(posedge memory_done) disable iff (!rst_n)
        fault === exp_fault)
        else report_mismatch("fault", $sampled(fault), $sampled(exp_fault));
    check_data: assert property (@(posedge memory_done) disable iff (!rst_n)
        exp_valid |-> load_data === exp_data)
        else report_mismatch("load_data", $sampled(load_data), $sampled(exp_data));
    check_reset_data: assert property (@(posedge memory_done) disable iff (!rst_n)
        reset_check |-> load_data === '0)
        else report_mismatch("load_data", $sampled(load_data), 32'd0);
    check_cfg: assert property (@(posedge memory_done) disable iff (!rst_n)
        cfg_check |-> cfg_rdata === cfg_exp)
        else report_mismatch("cfg_rdata", $sampled(cfg_rdata), $sampled(cfg_exp));

    initial
    begin
        logic [31:0]                     r;
        logic [31:0]                     a;
        logic [31:0]                     sel;
        logic [lsu_pkg::window_bits-1:0] new_base;
        rst_n = 1'b0;
        opcode = 7'd0;
        funct3 = 3'd0;
        address = '0;
        store_data = '0;
        cfg_we = 1'b0;
        cfg_addr = '0;
        cfg_wdata = '0;
        cfg_exp = '0;
        cfg_check = 1'b0;
        reset_check = 1'b0;
        exp_valid = 1'b0;
        exp_fault = 1'b0;
        exp_data = '0;
        window_model = '0;
        fault_total = 0;
        failures = 0;
        lfsr_state = 32'he68b_47ea;
        repeat (10) @(posedge memory_done);
        #1;
        rst_n = 1'b1;
        reset_check = 1'b1;
        read_cfg(lsu_pkg::cfg_window_base, 32'd0);
        read_cfg(lsu_pkg::cfg_fault_count, 32'd0);

        // Known contents everywhere before sub-word traffic
        for (int i = 0; i < lsu_pkg::mem_depth; i++)
        begin
            rand_bits(32, r);
            issue(lsu_pkg::opcode_store, lsu_pkg::f3_w, i << 2, r);
        end
        for (int i = 0; i < 40; i++)
        begin
            rand_bits(8, a);
            rand_bits(32, r);
            issue(lsu_pkg::opcode_store, lsu_pkg::f3_w, a << 2, r);
            issue(lsu_pkg::opcode_load, lsu_pkg::f3_w, a << 2, 0); // Reads the new word
        end

        for (int i = 0; i < 120; i++)
        begin
            rand_bits(3, sel);
            rand_bits(10, a);
            rand_bits(32, r);
            case (sel[2:0])
                3'd0: issue(lsu_pkg::opcode_store, lsu_pkg::f3_b, a, r);
                3'd1: issue(lsu_pkg::opcode_store, lsu_pkg::f3_h, {a[31:1], 1'b0}, r);
                3'd2: issue(lsu_pkg::opcode_load, lsu_pkg::f3_b, a, 0);
                3'd3: issue(lsu_pkg::opcode_load, lsu_pkg::f3_h, {a[31:1], 1'b0}, 0);
                3'd4: issue(lsu_pkg::opcode_load, lsu_pkg::f3_bu, a, 0);
                3'd5: issue(lsu_pkg::opcode_load, lsu_pkg::f3_hu, {a[31:1], 1'b0}, 0);
                default: issue(lsu_pkg::opcode_load, lsu_pkg::f3_w, {a[31:2], 2'b00}, 0);
            endcase
        end

        rand_bits(8, a);
        issue(lsu_pkg::opcode_load, lsu_pkg::f3_h, (a << 2) | 1, 0);
        read_cfg(lsu_pkg::cfg_fault_count, fault_total);
        issue(lsu_pkg::opcode_load, lsu_pkg::f3_w, (a << 2) | 2, 0);
        read_cfg(lsu_pkg::cfg_fault_count, fault_total);
        issue(lsu_pkg::opcode_store, lsu_pkg::f3_h, (a << 2) | 3, 32'hdead_beef);
        read_cfg(lsu_pkg::cfg_fault_count, fault_total);
        issue(lsu_pkg::opcode_store, lsu_pkg::f3_w, (a << 2) | 1, 32'hdead_beef);
        read_cfg(lsu_pkg::cfg_fault_count, fault_total);
        issue(lsu_pkg::opcode_load, lsu_pkg::f3_w, a << 2, 0); // Word must be untouched

        rand_bits(lsu_pkg::window_bits, r);
        new_base = r[lsu_pkg::window_bits-1:0] | 1'b1;
        write_cfg(lsu_pkg::cfg_window_base, 32'(new_base));
        read_cfg(lsu_pkg::cfg_window_base, 32'(new_base));
        issue(lsu_pkg::opcode_load, lsu_pkg::f3_w, a << 2, 0); // Old window now refused
        issue(lsu_pkg::opcode_load, lsu_pkg::f3_w, {new_base, a[7:0], 2'b00}, 0);
        read_cfg(lsu_pkg::cfg_fault_count, fault_total);
        write_cfg(lsu_pkg::cfg_fault_count, 32'd0);
        read_cfg(lsu_pkg::cfg_fault_count, 32'd0);

        // Back-to-back loads keep two in flight
        for (int i = 0; i < 32; i++)
        begin
            rand_bits(8, a);
            issue(lsu_pkg::opcode_load, lsu_pkg::f3_w, {new_base, a[7:0], 2'b00}, 0);
        end
        flush(8);

        if (failures == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

/* load_store_unit.sv */
// Top of the data-memory side of the core
// Loads return two memory_done edges after issue, faults pulse at the same point
module load_store_unit (
    input  logic                                memory_done,
    input  logic                                rst_n,
    input  logic [6:0]                          opcode,
    input  logic [2:0]                          funct3,
    input  logic [lsu_pkg::xlen-1:0]            address,
    input  logic [lsu_pkg::xlen-1:0]            store_data,
    output logic [lsu_pkg::xlen-1:0]            load_data,
    output logic                                load_valid,
    output logic                                fault,
    input  logic                                cfg_we,
    input  logic [lsu_pkg::cfg_addr_width-1:0]  cfg_addr,
    input  logic [lsu_pkg::xlen-1:0]            cfg_wdata,
    output logic [lsu_pkg::xlen-1:0]            cfg_rdata
);

    logic [lsu_pkg::window_bits-1:0]    window_base;
    logic                               access_fault;
    logic                               mem_en;
    logic                               mem_we;
    logic [3:0]                         byte_mask;
    logic [lsu_pkg::mem_addr_width-1:0] word_index;
    logic [lsu_pkg::xlen-1:0]           lane_data;
    logic                               is_load;
    logic [1:0]                         byte_offset;
    logic [lsu_pkg::xlen-1:0]           read_word;

    lsu_config_regs u_config_regs (
        .memory_done  (memory_done),
        .rst_n        (rst_n),
        .cfg_we       (cfg_we),
        .cfg_addr     (cfg_addr),
        .cfg_wdata    (cfg_wdata),
        .cfg_rdata    (cfg_rdata),
        .access_fault (access_fault),
        .window_base  (window_base)
    );

    lsu_access_decoder u_decoder (
        .opcode       (opcode),
        .funct3       (funct3),
        .address      (address),
        .store_data   (store_data),
        .window_base  (window_base),
        .mem_en       (mem_en),
        .mem_we       (mem_we),
        .byte_mask    (byte_mask),
        .word_index   (word_index),
        .lane_data    (lane_data),
        .is_load      (is_load),
        .byte_offset  (byte_offset),
        .access_fault (access_fault)
    );

    data_memory u_data_memory (
        .memory_done (memory_done),
        .mem_en      (mem_en),
        .mem_we      (mem_we),
        .byte_mask   (byte_mask),
        .word_index  (word_index),
        .lane_data   (lane_data),
        .read_word   (read_word)
    );

    // funct3 goes straight in, the aligner delays it itself
    load_aligner u_load_aligner (
        .memory_done  (memory_done),
        .rst_n        (rst_n),
        .is_load      (is_load),
        .funct3       (funct3),
        .byte_offset  (byte_offset),
        .access_fault (access_fault),
        .read_word    (read_word),
        .load_data    (load_data),
        .load_valid   (load_valid),
        .fault        (fault)
    );

endmodule

/* load_aligner.sv */
// Second load stage that lines up control with the memory read
// and extracts, extends and registers the load result
module load_aligner (
    input  logic                        memory_done,
    input  logic                        rst_n,
    input  logic                        is_load,
    input  logic [2:0]                  funct3,
    input  logic [1:0]                  byte_offset,
    input  logic                        access_fault,
    input  logic [lsu_pkg::xlen-1:0]    read_word,
    output logic [lsu_pkg::xlen-1:0]    load_data,
    output logic                        load_valid,
    output logic                        fault
);

    logic                     is_load_q;
    logic [2:0]               funct3_q;
    logic [1:0]               offset_q;
    logic                     fault_q;
    logic [lsu_pkg::xlen-1:0] shifted;
    logic [lsu_pkg::xlen-1:0] aligned;

    // Same latency as the memory read
    always_ff @(posedge memory_done or negedge rst_n)
    begin
        if (!rst_n)
        begin
            is_load_q <= 1'b0;
            funct3_q  <= 3'b000;
            offset_q  <= 2'b00;
            fault_q   <= 1'b0;
        end
        else
        begin
            is_load_q <= is_load;
            funct3_q  <= funct3;
            offset_q  <= byte_offset;
            fault_q   <= access_fault;
        end
    end

    assign shifted = read_word >> {offset_q, 3'b000}; // Addressed byte to bit 0

    always_comb
    begin
        case (funct3_q)
            lsu_pkg::f3_b:  aligned = {{(lsu_pkg::xlen-8){shifted[7]}}, shifted[7:0]};
            lsu_pkg::f3_h:  aligned = {{(lsu_pkg::xlen-16){shifted[15]}}, shifted[15:0]};
            lsu_pkg::f3_bu: aligned = {{(lsu_pkg::xlen-8){1'b0}}, shifted[7:0]};
            lsu_pkg::f3_hu: aligned = {{(lsu_pkg::xlen-16){1'b0}}, shifted[15:0]};
            default:        aligned = read_word; // LW
        endcase
    end

    always_ff @(posedge memory_done or negedge rst_n)
    begin
        if (!rst_n)
        begin
            load_data  <= '0;
            load_valid <= 1'b0;
            fault      <= 1'b0;
        end
        else
        begin
            load_valid <= is_load_q && !fault_q;
            fault      <= fault_q;
            if (is_load_q && !fault_q)
            begin
                load_data <= aligned; // Holds last result otherwise
            end
        end
    end

    // A returned load carries no unknown bits
    a_load_data_known: assert property (
        @(posedge memory_done) disable iff (!rst_n)
        load_valid |-> !$isunknown(load_data)
    );

endmodule

/* data_memory.sv */
// Word-wide data memory with per-byte write enables
// Read data appears one memory_done edge after the request
module data_memory (
    input  logic                                memory_done,
    input  logic                                mem_en,
    input  logic                                mem_we,
    input  logic [3:0]                          byte_mask,
    input  logic [lsu_pkg::mem_addr_width-1:0]  word_index,
    input  logic [lsu_pkg::xlen-1:0]            lane_data,
    output logic [lsu_pkg::xlen-1:0]            read_word
);

    logic [lsu_pkg::xlen-1:0] mem [lsu_pkg::mem_depth];

    always_ff @(posedge memory_done)
    begin
        if (mem_en)
        begin
            if (mem_we)
            begin
                // Only the selected lanes change
                for (int i = 0; i < 4; i++)
                begin
                    if (byte_mask[i])
                    begin
                        mem[word_index][8*i +: 8] <= lane_data[8*i +: 8];
                    end
                end
            end
            else
            begin
                read_word <= mem[word_index]; // Registered read
            end
        end
    end

    // Write strobe is only meaningful with the enable
    a_we_needs_en: assert property (
        @(posedge memory_done) mem_we |-> mem_en
    );

endmodule

/* lsu_access_decoder.sv */
// Combinational decode of RV32I loads and stores into memory controls
// Refuses misaligned accesses and addresses outside the configured window
module lsu_access_decoder (
    input  logic [6:0]                          opcode,
    input  logic [2:0]                          funct3,
    input  logic [lsu_pkg::xlen-1:0]            address,
    input  logic [lsu_pkg::xlen-1:0]            store_data,
    input  logic [lsu_pkg::window_bits-1:0]     window_base,
    output logic                                mem_en,
    output logic                                mem_we,
    output logic [3:0]                          byte_mask,
    output logic [lsu_pkg::mem_addr_width-1:0]  word_index,
    output logic [lsu_pkg::xlen-1:0]            lane_data,
    output logic                                is_load,
    output logic [1:0]                          byte_offset,
    output logic                                access_fault
);

    logic       is_load_op;
    logic       is_store_op;
    logic       size_known;
    logic [1:0] size;           // 0 byte, 1 halfword, 2 word
    logic       is_access;
    logic       misaligned;
    logic       out_of_window;

    assign is_load_op  = (opcode == lsu_pkg::opcode_load);
    assign is_store_op = (opcode == lsu_pkg::opcode_store);

    // Unsigned sizes only exist for loads
    always_comb
    begin
        size       = 2'd0;
        size_known = 1'b1;
        case (funct3)
            lsu_pkg::f3_b:  size = 2'd0;
            lsu_pkg::f3_h:  size = 2'd1;
            lsu_pkg::f3_w:  size = 2'd2;
            lsu_pkg::f3_bu:
            begin
                size       = 2'd0;
                size_known = is_load_op;
            end
            lsu_pkg::f3_hu:
            begin
                size       = 2'd1;
                size_known = is_load_op;
            end
            default: size_known = 1'b0;
        endcase
    end

    assign is_access     = (is_load_op || is_store_op) && size_known;
    assign misaligned    = ((size == 2'd1) && address[0]) ||
                           ((size == 2'd2) && (address[1:0] != 2'b00));
    assign out_of_window = (address[lsu_pkg::xlen-1 -: lsu_pkg::window_bits] != window_base);

    assign access_fault = is_access && (misaligned || out_of_window);
    assign mem_en       = is_access && !access_fault; // Refused accesses never reach memory
    assign mem_we       = mem_en && is_store_op;
    assign is_load      = is_access && is_load_op;
    assign byte_offset  = address[1:0];
    assign word_index   = address[lsu_pkg::mem_addr_width+1:2];

    // Lane i holds byte offset i
    always_comb
    begin
        case (size)
            2'd0:    byte_mask = 4'b0001 << address[1:0];
            2'd1:    byte_mask = address[1] ? 4'b1100 : 4'b0011;
            default: byte_mask = 4'b1111;
        endcase
    end

    always_comb
    begin
        case (size)
            2'd0:    lane_data = {4{store_data[7:0]}};  // Copy byte to every lane
            2'd1:    lane_data = {2{store_data[15:0]}};
            default: lane_data = store_data;
        endcase
    end

endmodule

/* lsu_config_regs.sv */
// Configuration and status registers beside the access decoder
// Holds the memory window base and a saturating count of refused accesses
module lsu_config_regs (
    input  logic                                memory_done,
    input  logic                                rst_n,
    input  logic                                cfg_we,
    input  logic [lsu_pkg::cfg_addr_width-1:0]  cfg_addr,
    input  logic [lsu_pkg::xlen-1:0]            cfg_wdata,
    output logic [lsu_pkg::xlen-1:0]            cfg_rdata,
    input  logic                                access_fault,
    output logic [lsu_pkg::window_bits-1:0]     window_base
);

    logic [lsu_pkg::xlen-1:0] fault_count;
    logic                     base_wr;
    logic                     count_clr;

    assign base_wr   = cfg_we && (cfg_addr == lsu_pkg::cfg_window_base);
    assign count_clr = cfg_we && (cfg_addr == lsu_pkg::cfg_fault_count);

    always_ff @(posedge memory_done or negedge rst_n)
    begin
        if (!rst_n)
        begin
            window_base <= '0;
        end
        else if (base_wr)
        begin
            window_base <= cfg_wdata[lsu_pkg::window_bits-1:0]; // Upper wdata bits dropped
        end
    end

    // Clear from software wins over a fault in the same cycle
    always_ff @(posedge memory_done or negedge rst_n)
    begin
        if (!rst_n)
        begin
            fault_count <= '0;
        end
        else if (count_clr)
        begin
            fault_count <= '0;
        end
        else if (access_fault && (fault_count != '1))
        begin
            fault_count <= fault_count + 1'b1; // Sticks at all ones
        end
    end

    always_comb
    begin
        case (cfg_addr)
            lsu_pkg::cfg_window_base: cfg_rdata = lsu_pkg::xlen'(window_base);
            lsu_pkg::cfg_fault_count: cfg_rdata = fault_count;
            default:                  cfg_rdata = '0;
        endcase
    end

    // A register write must target a defined address
    a_cfg_addr_known: assert property (
        @(posedge memory_done) disable iff (!rst_n)
        cfg_we |-> !$isunknown(cfg_addr)
    );

endmodule

/* lsu_pkg.sv */
// Shared constants for the load/store unit RTL and its testbench
// Reference them through lsu_pkg:: scoped names
package lsu_pkg;

    // RV32I major opcodes
    localparam logic [6:0] opcode_load  = 7'b0000011;
    localparam logic [6:0] opcode_store = 7'b0100011;

    // funct3 access sizes
    localparam logic [2:0] f3_b  = 3'b000;
    localparam logic [2:0] f3_h  = 3'b001;
    localparam logic [2:0] f3_w  = 3'b010;
    localparam logic [2:0] f3_bu = 3'b100;
    localparam logic [2:0] f3_hu = 3'b101;

    localparam int xlen = 32; // Data path width

    // Word-addressed data memory
    localparam int mem_addr_width = 8;
    localparam int mem_depth      = 1 << mem_addr_width;

    // Upper address bits above the word index and byte offset
    // These must equal the programmed window base
    localparam int window_bits = xlen - mem_addr_width - 2;

    // Configuration register map
    localparam int cfg_addr_width = 2;
    localparam logic [cfg_addr_width-1:0] cfg_window_base = 2'd0;
    localparam logic [cfg_addr_width-1:0] cfg_fault_count = 2'd1;

endpackage
